// ==== rtl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_branch   = 7'b1100011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_imm      = 7'b0010011,
        op_reg      = 7'b0110011,
        op_system   = 7'b1110011,
        op_load_fp  = 7'b0000111,
        op_store_fp = 7'b0100111,
        op_fp       = 7'b1010011
    } opcode_e;

    typedef enum logic [2:0] {
        imm_i   = 3'd0,
        imm_s   = 3'd1,
        imm_b   = 3'd2,
        imm_u   = 3'd3,
        imm_j   = 3'd4,
        imm_csr = 3'd5
    } imm_src_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui result is the immediate itself
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu      = 2'd0,
        res_mem      = 2'd1,
        res_pc_plus4 = 2'd2,
        res_csr      = 2'd3
    } result_src_e;

    localparam logic [11:0] csr_status_addr       = 12'h300;
    localparam logic [11:0] csr_scratch_addr      = 12'h340;
    localparam logic [11:0] csr_result_bytes_addr = 12'h7C0;

endpackage

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit import decode_pkg::*; (
    input  opcode_e     opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7_5,
    output logic        reg_write,
    output logic        fpu_reg_write,
    output logic        mem_write,
    output logic        branch,
    output logic        jump,
    output logic        alu_src,
    output logic        csr_write,
    output logic        csr_src,
    output logic        illegal,
    output alu_op_e     alu_op,
    output result_src_e result_src,
    output imm_src_e    imm_src
);

    // alt selects sub/sra, only meaningful for register-register ops
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        reg_write     = 1'b0;
        fpu_reg_write = 1'b0;
        mem_write     = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        alu_src       = 1'b0;
        csr_write     = 1'b0;
        csr_src       = 1'b0;
        illegal       = 1'b0;
        alu_op        = alu_add;
        result_src    = res_alu;
        imm_src       = imm_i;
        case (opcode)
            op_lui: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_pass_b;
                imm_src   = imm_u;
            end
            op_auipc: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_u;
            end
            op_jal: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                result_src = res_pc_plus4;
                imm_src    = imm_j;
            end
            op_jalr: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                alu_src    = 1'b1;
                result_src = res_pc_plus4;
            end
            op_branch: begin
                // compare by subtraction
                branch  = 1'b1;
                alu_op  = alu_sub;
                imm_src = imm_b;
            end
            op_load: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_src = res_mem;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_s;
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_from_funct3(funct3, 1'b0);
            end
            op_reg: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct3(funct3, funct7_5);
            end
            op_system: begin
                // funct3 of zero is ecall/ebreak, nothing written here
                if (funct3 != 3'b000) begin
                    reg_write  = 1'b1;
                    csr_write  = 1'b1;
                    csr_src    = funct3[2];
                    result_src = res_csr;
                    imm_src    = imm_csr;
                end
            end
            op_load_fp: begin
                fpu_reg_write = 1'b1;
                alu_src       = 1'b1;
                result_src    = res_mem;
            end
            op_store_fp: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_s;
            end
            op_fp: begin
                fpu_reg_write = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        assert (!(illegal && (reg_write || fpu_reg_write || mem_write || csr_write)))
            else $error("illegal instruction decoded with a write enable set");
    end

endmodule

`default_nettype wire

// ==== rtl/imm_extend.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_extend import decode_pkg::*; (
    input  logic [31:0] instr,
    input  imm_src_e    imm_src,
    output logic [31:0] imm_ext
);

    always_comb begin
        case (imm_src)
            imm_i: begin
                imm_ext = {{20{instr[31]}}, instr[31:20]};
            end
            imm_s: begin
                imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            imm_b: begin
                // branch offsets are halfword aligned
                imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            imm_u: begin
                imm_ext = {instr[31:12], 12'b0};
            end
            imm_j: begin
                imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            imm_csr: begin
                // csr address, never sign extended
                imm_ext = {20'b0, instr[31:20]};
            end
            default: begin
                imm_ext = 32'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile #(
    parameter bit zero_reg = 1'b1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  a1,
    input  logic [4:0]  a2,
    input  logic [4:0]  a3,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];
    logic        wr_en;

    // x0 style register drops writes
    assign wr_en = we && !(zero_reg && a3 == 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_en) begin
            regs[a3] <= wd;
        end
    end

    // write-first bypass on both ports
    always_comb begin
        if (zero_reg && a1 == 5'd0) begin
            rd1 = 32'b0;
        end else if (wr_en && a3 == a1) begin
            rd1 = wd;
        end else begin
            rd1 = regs[a1];
        end
        if (zero_reg && a2 == 5'd0) begin
            rd2 = 32'b0;
        end else if (wr_en && a3 == a2) begin
            rd2 = wd;
        end else begin
            rd2 = regs[a2];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module csr_file import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [11:0] addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    output logic [31:0] status,
    output logic [31:0] result_bytes
);

    logic [31:0] scratch;
    logic        sel_status;
    logic        sel_scratch;
    logic        sel_result_bytes;

    assign sel_status       = (addr == csr_status_addr);
    assign sel_scratch      = (addr == csr_scratch_addr);
    assign sel_result_bytes = (addr == csr_result_bytes_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            status       <= 32'b0;
            scratch      <= 32'b0;
            result_bytes <= 32'b0;
        end else if (we) begin
            if (sel_status) begin
                // bit 0 marks that software touched status
                status <= din | 32'h1;
            end
            if (sel_scratch) begin
                scratch <= din;
            end
            if (sel_result_bytes) begin
                result_bytes <= din;
            end
        end
    end

    // old value, unknown addresses read zero
    always_comb begin
        if (sel_status) begin
            dout = status;
        end else if (sel_scratch) begin
            dout = scratch;
        end else if (sel_result_bytes) begin
            dout = result_bytes;
        end else begin
            dout = 32'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        we |-> (sel_status || sel_scratch || sel_result_bytes))
        else $error("csr write to unknown address %h", addr);

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode import decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic        stall,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [4:0]  rd_w,
    input  logic [31:0] result_w,
    input  logic        reg_write_w,
    input  logic [31:0] fpu_result_w,
    input  logic        fpu_reg_write_w,
    output logic        out_valid,
    output logic        reg_write,
    output logic        fpu_reg_write,
    output logic        mem_write,
    output logic        branch,
    output logic        jump,
    output logic        alu_src,
    output logic        illegal,
    output alu_op_e     alu_op,
    output result_src_e result_src,
    output logic [31:0] pc_out,
    output logic [31:0] pc_plus4,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] fpu_rd1,
    output logic [31:0] fpu_rd2,
    output logic [31:0] imm_ext,
    output logic [31:0] csr_data,
    output logic [31:0] status,
    output logic [31:0] result_bytes,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [2:0]  rm,
    output logic [4:0]  funct5
);

    logic [4:0]  rs1_d;
    logic [4:0]  rs2_d;
    logic        reg_write_d;
    logic        fpu_reg_write_d;
    logic        mem_write_d;
    logic        branch_d;
    logic        jump_d;
    logic        alu_src_d;
    logic        csr_write_d;
    logic        csr_src_d;
    logic        illegal_d;
    alu_op_e     alu_op_d;
    result_src_e result_src_d;
    imm_src_e    imm_src_d;
    logic [31:0] imm_ext_d;
    logic [31:0] rd1_d;
    logic [31:0] rd2_d;
    logic [31:0] fpu_rd1_d;
    logic [31:0] fpu_rd2_d;
    logic [31:0] csr_din;
    logic [31:0] csr_dout;
    logic        csr_we;
    logic        accept;

    assign rs1_d  = instr[19:15];
    assign rs2_d  = instr[24:20];
    assign accept = in_valid && !stall;

    control_unit i_control_unit (
        .opcode       (opcode_e'(instr[6:0])),
        .funct3       (instr[14:12]),
        .funct7_5     (instr[30]),
        .reg_write    (reg_write_d),
        .fpu_reg_write(fpu_reg_write_d),
        .mem_write    (mem_write_d),
        .branch       (branch_d),
        .jump         (jump_d),
        .alu_src      (alu_src_d),
        .csr_write    (csr_write_d),
        .csr_src      (csr_src_d),
        .illegal      (illegal_d),
        .alu_op       (alu_op_d),
        .result_src   (result_src_d),
        .imm_src      (imm_src_d)
    );

    imm_extend i_imm_extend (
        .instr  (instr),
        .imm_src(imm_src_d),
        .imm_ext(imm_ext_d)
    );

    regfile #(
        .zero_reg(1'b1)
    ) int_rf (
        .clk  (clk),
        .reset(reset),
        .we   (reg_write_w),
        .a1   (rs1_d),
        .a2   (rs2_d),
        .a3   (rd_w),
        .wd   (result_w),
        .rd1  (rd1_d),
        .rd2  (rd2_d)
    );

    // fp register 0 is an ordinary register
    regfile #(
        .zero_reg(1'b0)
    ) fpu_rf (
        .clk  (clk),
        .reset(reset),
        .we   (fpu_reg_write_w),
        .a1   (rs1_d),
        .a2   (rs2_d),
        .a3   (rd_w),
        .wd   (fpu_result_w),
        .rd1  (fpu_rd1_d),
        .rd2  (fpu_rd2_d)
    );

    // zimm form takes the rs1 field itself
    assign csr_din = csr_src_d ? {27'b0, rs1_d} : rd1_d;
    assign csr_we  = csr_write_d && accept;

    csr_file i_csr_file (
        .clk         (clk),
        .reset       (reset),
        .we          (csr_we),
        .addr        (imm_ext_d[11:0]),
        .din         (csr_din),
        .dout        (csr_dout),
        .status      (status),
        .result_bytes(result_bytes)
    );

    // control outputs, inactive for a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid     <= 1'b0;
            reg_write     <= 1'b0;
            fpu_reg_write <= 1'b0;
            mem_write     <= 1'b0;
            branch        <= 1'b0;
            jump          <= 1'b0;
            alu_src       <= 1'b0;
            illegal       <= 1'b0;
            alu_op        <= alu_add;
            result_src    <= res_alu;
        end else if (!stall) begin
            out_valid     <= in_valid;
            reg_write     <= in_valid && reg_write_d;
            fpu_reg_write <= in_valid && fpu_reg_write_d;
            mem_write     <= in_valid && mem_write_d;
            branch        <= in_valid && branch_d;
            jump          <= in_valid && jump_d;
            alu_src       <= in_valid && alu_src_d;
            illegal       <= in_valid && illegal_d;
            alu_op        <= alu_op_d;
            result_src    <= result_src_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_out   <= pc;
            pc_plus4 <= pc + 32'd4;
            rd1      <= rd1_d;
            rd2      <= rd2_d;
            fpu_rd1  <= fpu_rd1_d;
            fpu_rd2  <= fpu_rd2_d;
            imm_ext  <= imm_ext_d;
            csr_data <= csr_dout;
            rs1      <= rs1_d;
            rs2      <= rs2_d;
            rd       <= instr[11:7];
            rm       <= instr[14:12];
            funct5   <= instr[31:27];
        end
    end

    assert property (@(posedge clk) disable iff (reset) stall |=> $stable(out_valid))
        else $error("out_valid changed while stalled");

endmodule

`default_nettype wire

// ==== test/tb_checks.svh ====
`ifndef tb_checks_svh
`define tb_checks_svh

task automatic check_word(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
    if (actual !== expected) begin
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

task automatic check_alu_op(input string name, input alu_op_e expected,
        input alu_op_e actual);
    if (actual !== expected) begin
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

task automatic check_result_src(input string name, input result_src_e expected,
        input result_src_e actual);
    if (actual !== expected) begin
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

// one valid instruction, sampled after it lands in the output register
task automatic issue(input logic [31:0] ins, input logic [31:0] pc_value);
    @(posedge clk);
    in_valid <= 1'b1;
    instr    <= ins;
    pc       <= pc_value;
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
endtask

task automatic issue_during_write(input logic [31:0] ins, input logic [4:0] dest,
        input logic [31:0] value);
    @(posedge clk);
    in_valid    <= 1'b1;
    instr       <= ins;
    pc          <= 32'h0000_1800;
    rd_w        <= dest;
    result_w    <= value;
    reg_write_w <= 1'b1;
    @(posedge clk);
    in_valid    <= 1'b0;
    reg_write_w <= 1'b0;
    if (dest != 5'd0) begin
        int_model[dest] = value;
    end
    @(negedge clk);
endtask

task automatic write_back(input logic [4:0] dest, input logic [31:0] value,
        input logic to_fp);
    @(posedge clk);
    rd_w <= dest;
    if (to_fp) begin
        fpu_result_w    <= value;
        fpu_reg_write_w <= 1'b1;
    end else begin
        result_w    <= value;
        reg_write_w <= 1'b1;
    end
    @(posedge clk);
    reg_write_w     <= 1'b0;
    fpu_reg_write_w <= 1'b0;
    // fp f0 is a normal register, int x0 is not
    if (to_fp) begin
        fp_model[dest] = value;
    end else if (dest != 5'd0) begin
        int_model[dest] = value;
    end
endtask

`endif

// ==== test/tb_instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_instr_decode import decode_pkg::*; ();

    localparam int clk_period     = 4;
    localparam int reset_cycles   = 16;
    // cycle budget per test, two cycles per issued instruction
    localparam int int_rf_cycles  = 32 * 2 + 8 * 2 + 2 * 2;
    localparam int fp_rf_cycles   = 4 * 2 + 2 * 2;
    localparam int imm_cycles     = 5 * 6 * 2;
    localparam int control_cycles = 21 * 2;
    localparam int csr_cycles     = 30;
    localparam int total_cycles   = reset_cycles + 2 + int_rf_cycles + fp_rf_cycles
                                    + imm_cycles + control_cycles + csr_cycles;
    localparam int timeout_ns     = total_cycles * clk_period + 200;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        stall;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [4:0]  rd_w;
    logic [31:0] result_w;
    logic        reg_write_w;
    logic [31:0] fpu_result_w;
    logic        fpu_reg_write_w;
    logic        out_valid;
    logic        reg_write;
    logic        fpu_reg_write;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        alu_src;
    logic        illegal;
    alu_op_e     alu_op;
    result_src_e result_src;
    logic [31:0] pc_out;
    logic [31:0] pc_plus4;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] fpu_rd1;
    logic [31:0] fpu_rd2;
    logic [31:0] imm_ext;
    logic [31:0] csr_data;
    logic [31:0] status;
    logic [31:0] result_bytes;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  rm;
    logic [4:0]  funct5;

    // expected register contents
    logic [31:0] int_model [32];
    logic [31:0] fp_model [32];
    opcode_e     imm_formats [5] = '{op_imm, op_store, op_branch, op_lui, op_jal};
    int unsigned seed_value;

    instr_decode UUT (.*);

    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "decode testbench stopped");
    endtask

    `include "tb_checks.svh"

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2_f,
            input logic [4:0] rs1_f, input logic [2:0] f3, input logic [4:0] rd_f,
            input opcode_e op);
        return {f7, rs2_f, rs1_f, f3, rd_f, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1_f,
            input logic [2:0] f3, input logic [4:0] rd_f, input opcode_e op);
        return {imm12, rs1_f, f3, rd_f, op};
    endfunction

    // immediate per RISC-V format, built from an arithmetic shift of the word
    function automatic logic [31:0] expected_imm(input logic [31:0] ins);
        logic [31:0] sext;
        sext = $signed(ins) >>> 20;
        case (opcode_e'(ins[6:0]))
            op_imm:    return sext;
            op_store:  return {sext[31:5], ins[11:7]};
            op_branch: return {sext[31:12], ins[7], ins[30:25], ins[11:8], 1'b0};
            op_lui:    return {ins[31:12], 12'h000};
            op_jal:    return {sext[31:20], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:   return 32'h0;
        endcase
    endfunction

    task automatic check_idle(input string when);
        @(negedge clk);
        check_bit({"out_valid ", when}, 1'b0, out_valid);
        check_bit({"reg_write ", when}, 1'b0, reg_write);
        check_bit({"fpu_reg_write ", when}, 1'b0, fpu_reg_write);
        check_bit({"mem_write ", when}, 1'b0, mem_write);
        check_bit({"branch ", when}, 1'b0, branch);
        check_bit({"jump ", when}, 1'b0, jump);
        check_bit({"illegal ", when}, 1'b0, illegal);
    endtask

    // flags are {reg_write, fpu_reg_write, mem_write, branch, jump, alu_src, illegal}
    task automatic check_control(input logic [31:0] ins, input logic [6:0] flags,
            input alu_op_e op, input result_src_e res);
        issue(ins, 32'h0000_2000);
        check_bit("out_valid", 1'b1, out_valid);
        check_bit("reg_write", flags[6], reg_write);
        check_bit("fpu_reg_write", flags[5], fpu_reg_write);
        check_bit("mem_write", flags[4], mem_write);
        check_bit("branch", flags[3], branch);
        check_bit("jump", flags[2], jump);
        check_bit("alu_src", flags[1], alu_src);
        check_bit("illegal", flags[0], illegal);
        check_alu_op("alu_op", op, alu_op);
        check_result_src("result_src", res, result_src);
        check_word("pc_plus4", 32'h0000_2004, pc_plus4);
    endtask

    task automatic test_int_regfile();
        logic [31:0] v;
        logic [4:0]  a;
        logic [4:0]  b;
        for (int r = 0; r < 32; r++) begin
            v = $urandom();
            write_back(5'(r), v, 1'b0);
        end
        for (int r = 0; r < 32; r += 4) begin
            a = 5'(r);
            b = 5'(31 - r);
            issue(r_type(7'h00, b, a, 3'b000, 5'd9, op_reg), 32'h0000_1000);
            check_word("rd1", int_model[a], rd1);
            check_word("rd2", int_model[b], rd2);
        end
        v = $urandom();
        issue_during_write(r_type(7'h00, 5'd12, 5'd12, 3'b000, 5'd9, op_reg), 5'd12, v);
        check_word("rd1 bypass", v, rd1);
        check_word("rd2 bypass", v, rd2);
        // x0 ignores the write even in the bypass path
        issue_during_write(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd9, op_reg), 5'd0, v | 32'h1);
        check_word("rd1 x0", 32'h0, rd1);
        check_word("rd2 x0", 32'h0, rd2);
    endtask

    task automatic test_fp_regfile();
        logic [31:0] v;
        for (int r = 0; r < 4; r++) begin
            v = $urandom() | 32'h1;
            write_back(5'(r), v, 1'b1);
        end
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, op_fp), 32'h0000_1400);
        check_word("fpu_rd1 f0", fp_model[0], fpu_rd1);
        check_word("fpu_rd2 f0", fp_model[0], fpu_rd2);
        check_word("rd1 x0", 32'h0, rd1);
        // funct7 0x50 puts 0x14 in funct5
        issue(r_type(7'h50, 5'd1, 5'd3, 3'b010, 5'd7, op_fp), 32'h0000_1404);
        check_word("fpu_rd1", fp_model[3], fpu_rd1);
        check_word("fpu_rd2", fp_model[1], fpu_rd2);
        check_word("rd1 after fp writes", int_model[3], rd1);
        check_word("rd2 after fp writes", int_model[1], rd2);
        check_word("rs1", 32'h3, {27'h0, rs1});
        check_word("rs2", 32'h1, {27'h0, rs2});
        check_word("rd", 32'h7, {27'h0, rd});
        check_word("rm", 32'h2, {29'h0, rm});
        check_word("funct5", 32'h14, {27'h0, funct5});
    endtask

    task automatic test_immediates();
        logic [31:0] ins;
        for (int k = 0; k < 5; k++) begin
            for (int n = 0; n < 6; n++) begin
                ins = $urandom();
                ins[6:0] = imm_formats[k];
                issue(ins, 32'h0000_3000);
                check_word("imm_ext", expected_imm(ins), imm_ext);
            end
        end
    endtask

    task automatic test_control();
        check_control({20'h12345, 5'd3, op_lui}, 7'b1000010, alu_pass_b, res_alu);
        check_control({20'h00010, 5'd3, op_auipc}, 7'b1000010, alu_add, res_alu);
        check_control({20'h00100, 5'd1, op_jal}, 7'b1000100, alu_add, res_pc_plus4);
        check_control(i_type(12'h010, 5'd1, 3'b000, 5'd1, op_jalr), 7'b1000110, alu_add,
                      res_pc_plus4);
        check_control(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, op_branch), 7'b0001000,
                      alu_sub, res_alu);
        check_control(i_type(12'h004, 5'd1, 3'b010, 5'd4, op_load), 7'b1000010, alu_add,
                      res_mem);
        check_control(r_type(7'h00, 5'd4, 5'd1, 3'b010, 5'd8, op_store), 7'b0010010,
                      alu_add, res_alu);
        // bit 30 set on an immediate op is still add
        check_control(i_type(12'h400, 5'd1, 3'b000, 5'd2, op_imm), 7'b1000010, alu_add,
                      res_alu);
        check_control(i_type(12'h0ff, 5'd1, 3'b100, 5'd2, op_imm), 7'b1000010, alu_xor,
                      res_alu);
        check_control(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, op_reg), 7'b1000000, alu_add,
                      res_alu);
        check_control(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, op_reg), 7'b1000000, alu_sub,
                      res_alu);
        check_control(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, op_reg), 7'b1000000, alu_srl,
                      res_alu);
        check_control(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, op_reg), 7'b1000000, alu_sra,
                      res_alu);
        check_control(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, op_reg), 7'b1000000, alu_and,
                      res_alu);
        check_control(32'h0000_0073, 7'b0000000, alu_add, res_alu);
        check_control(i_type(csr_result_bytes_addr, 5'd0, 3'b001, 5'd0, op_system),
                      7'b1000000, alu_add, res_csr);
        check_word("imm_ext csr", {20'h0, csr_result_bytes_addr}, imm_ext);
        check_control(i_type(12'h008, 5'd1, 3'b010, 5'd4, op_load_fp), 7'b0100010, alu_add,
                      res_mem);
        check_control(r_type(7'h00, 5'd4, 5'd1, 3'b010, 5'd8, op_store_fp), 7'b0010010,
                      alu_add, res_alu);
        check_control(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, op_fp), 7'b0100000, alu_add,
                      res_alu);
        check_control(32'h0000_007f, 7'b0000001, alu_add, res_alu);
    endtask

    task automatic test_csr_and_stall();
        logic [31:0] v;
        logic [31:0] w;
        v = $urandom();
        w = $urandom();
        write_back(5'd5, v, 1'b0);
        write_back(5'd6, w, 1'b0);
        // each access returns what the previous one wrote
        issue(i_type(csr_scratch_addr, 5'd5, 3'b001, 5'd1, op_system), 32'h0000_4000);
        check_word("csr_data scratch reset", 32'h0, csr_data);
        issue(i_type(csr_scratch_addr, 5'd6, 3'b001, 5'd1, op_system), 32'h0000_4004);
        check_word("csr_data scratch", v, csr_data);
        issue(i_type(csr_scratch_addr, 5'd22, 3'b101, 5'd1, op_system), 32'h0000_4008);
        check_word("csr_data scratch", w, csr_data);
        issue(i_type(csr_scratch_addr, 5'd0, 3'b001, 5'd1, op_system), 32'h0000_400c);
        check_word("csr_data zimm", 32'd22, csr_data);
        issue(i_type(csr_status_addr, 5'd4, 3'b101, 5'd1, op_system), 32'h0000_4010);
        check_word("csr_data status", 32'h0, csr_data);
        check_bit("status[0]", 1'b1, status[0]);
        check_word("status", 32'h5, status);
        // result bytes held zero since the x0 write in the control test
        issue(i_type(csr_result_bytes_addr, 5'd6, 3'b001, 5'd1, op_system), 32'h0000_4014);
        check_word("csr_data result_bytes", 32'h0, csr_data);
        check_word("result_bytes", w, result_bytes);

        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd3, op_reg);
        pc       <= 32'h0000_42f0;
        @(posedge clk);
        stall <= 1'b1;
        instr <= i_type(csr_status_addr, 5'd5, 3'b001, 5'd2, op_system);
        pc    <= 32'h0000_4300;
        repeat (4) begin
            @(negedge clk);
            check_bit("out_valid stalled", 1'b1, out_valid);
            check_word("pc_out stalled", 32'h0000_42f0, pc_out);
            check_word("rd1 stalled", v, rd1);
            check_word("status stalled", 32'h5, status);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_word("csr_data after stall", 32'h5, csr_data);
        check_word("status after stall", v | 32'h1, status);
        check_word("pc_out after stall", 32'h0000_4300, pc_out);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the decode tests completed");
        end_with_failure();
    end

    initial begin
        seed_value = $urandom(15);
        reset           <= 1'b1;
        in_valid        <= 1'b0;
        stall           <= 1'b0;
        instr           <= 32'h0000_0013;
        pc              <= 32'h0;
        rd_w            <= 5'd0;
        result_w        <= 32'h0;
        reg_write_w     <= 1'b0;
        fpu_result_w    <= 32'h0;
        fpu_reg_write_w <= 1'b0;
        for (int r = 0; r < 32; r++) begin
            int_model[r] = 32'h0;
            fp_model[r]  = 32'h0;
        end
        repeat (reset_cycles / 2) @(posedge clk);
        check_idle("during reset");
        repeat (reset_cycles / 2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_idle("after reset");
        test_int_regfile();
        test_fp_regfile();
        test_immediates();
        test_control();
        test_csr_and_stall();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
rtl/decode_pkg.sv
rtl/control_unit.sv
rtl/imm_extend.sv
rtl/regfile.sv
rtl/csr_file.sv
rtl/instr_decode.sv
test/tb_instr_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_instr_decode -f flist.f -o sim_tb

sim_output=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
